// File: source/rv_pkg.sv
package rv_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] data_t;

	localparam data_t NULL = '0;

	typedef enum logic [6:0] {
		R     = 7'b0110011,
		I     = 7'b0010011,
		B     = 7'b1100011,
		LUI   = 7'b0110111,
		AUIPC = 7'b0010111,
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		LOAD  = 7'b0000011,
		STORE = 7'b0100011,
		MEM   = 7'b0001111,   // fence
		SYS   = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		ADD  = 3'b000,
		SLL  = 3'b001,
		SLT  = 3'b010,
		SLTU = 3'b011,
		XOR  = 3'b100,
		SRL  = 3'b101,
		OR   = 3'b110,
		AND  = 3'b111
	} funct3_t;

	// same encodings under other names
	localparam funct3_t SUB   = ADD;
	localparam funct3_t SRA   = SRL;
	localparam funct3_t ADDI  = ADD;
	localparam funct3_t SLLI  = SLL;
	localparam funct3_t SLTI  = SLT;
	localparam funct3_t SLTIU = SLTU;
	localparam funct3_t XORI  = XOR;
	localparam funct3_t SRLI  = SRL;
	localparam funct3_t SRAI  = SRL;
	localparam funct3_t ORI   = OR;
	localparam funct3_t ANDI  = AND;
	localparam funct3_t BEQ   = ADD;
	localparam funct3_t BNE   = SLL;
	localparam funct3_t BLT   = XOR;
	localparam funct3_t BGE   = SRL;
	localparam funct3_t BLTU  = OR;
	localparam funct3_t BGEU  = AND;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		funct3_t    funct3;
		logic [4:0] rd;
		opcode_t    opcode;
	} instr_t;

	typedef enum logic {logical, arithmetic} shift_type_t;
	typedef enum logic {signed_op, unsigned_op} sign_t;

	function automatic data_t get_imm(instr_t instr);
		logic [XLEN-1:0] raw;
		raw = instr;
		case (instr.opcode)
			I, JALR, LOAD: get_imm = {{20{raw[31]}}, raw[31:20]};
			STORE:         get_imm = {{20{raw[31]}}, raw[31:25], raw[11:7]};
			B:             get_imm = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
			LUI, AUIPC:    get_imm = {raw[31:12], 12'b0};
			JAL:           get_imm = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
			default:       get_imm = NULL;
		endcase
	endfunction

	typedef struct packed {
		data_t addr;
		data_t wdata;
		logic  we;
	} mem_req_t;

	typedef enum logic [1:0] {FETCH, EXECUTE, MEM_WAIT, WRITEBACK} core_state_t;

	typedef struct packed {
		data_t      pc;
		logic [4:0] rd;
		logic       we;
		data_t      data;
	} retire_t;

endpackage

// File: source/alu.sv
module alu (
	input rv_pkg::instr_t instr,
	input rv_pkg::data_t a_in,
	input rv_pkg::data_t b_in,
	input rv_pkg::data_t pc,

	output rv_pkg::data_t c_out,
	output logic rd_wr
);
	import rv_pkg::*;

	opcode_t     opcode;
	funct3_t     funct3;
	shift_type_t shift_type;
	sign_t       sign_op;
	data_t       imm;
	logic        sub_func;
	logic        is_cmp;
	logic        inv_b;

	data_t       op_b;          // rs2 or immediate, before inversion
	data_t       add_a;
	data_t       add_b;
	logic [XLEN:0] sum;         // carry out kept for unsigned compare
	data_t       add_result;
	logic        less;
	logic [4:0]  shamt;
	data_t       shift_result;
	data_t       op_result;

	always_comb begin : decode
		opcode = instr.opcode;
		funct3 = instr.funct3;
		imm = get_imm(instr);
		shift_type = shift_type_t'(instr.funct7[5]);   // bit 30
		sub_func = (opcode == R) && instr.funct7[5] && (funct3 == SUB);
		is_cmp = (opcode inside {R, I}) && (funct3 inside {SLT, SLTU});
		sign_op = (funct3 == SLTU) ? unsigned_op : signed_op;
		inv_b = sub_func | is_cmp;
	end

	// one adder for add, sub, compares, addresses and targets
	always_comb begin : adder
		op_b = (opcode == R) ? b_in : imm;
		add_a = (opcode inside {AUIPC, JAL}) ? pc : a_in;
		add_b = inv_b ? ~op_b : op_b;
		sum = {1'b0, add_a} + {1'b0, add_b} + (XLEN+1)'(inv_b);
		add_result = sum[XLEN-1:0];
	end

	always_comb begin : compare
		if (sign_op == unsigned_op)
			less = ~sum[XLEN];     // no borrow means a >= b
		else if (a_in[XLEN-1] != op_b[XLEN-1])
			less = a_in[XLEN-1];
		else
			less = sum[XLEN-1];
	end

	always_comb begin : shifter
		shamt = (opcode == R) ? b_in[4:0] : instr.rs2;
		case (funct3)
			SLL: shift_result = a_in << shamt;
			SRL: begin
				if (shift_type == arithmetic)
					shift_result = data_t'($signed(a_in) >>> shamt);
				else
					shift_result = a_in >> shamt;
			end
			default: shift_result = NULL;
		endcase
	end

	always_comb begin : op_sel
		case (funct3)
			AND:       op_result = a_in & op_b;
			OR:        op_result = a_in | op_b;
			XOR:       op_result = a_in ^ op_b;
			SLT, SLTU: op_result = {{(XLEN-1){1'b0}}, less};
			SLL, SRL:  op_result = shift_result;
			default:   op_result = add_result;   // add or sub
		endcase
	end

	always_comb begin : output_sel
		c_out = NULL;
		rd_wr = 1'b0;
		case (opcode)
			R, I: begin
				c_out = op_result;
				rd_wr = 1'b1;
			end
			LUI: begin
				c_out = imm;
				rd_wr = 1'b1;
			end
			AUIPC, JAL, LOAD: begin
				c_out = add_result;
				rd_wr = 1'b1;
			end
			JALR: begin
				c_out = {add_result[XLEN-1:1], 1'b0};  // target lsb cleared
				rd_wr = 1'b1;
			end
			STORE: c_out = add_result;
			default: c_out = NULL;   // branches, fence and system
		endcase
	end

	// a decoded register or immediate op gives a known result
	always_comb begin : known_check
		assert final ($isunknown(instr) || !(opcode inside {R, I})
				|| !$isunknown(c_out))
			else $error("alu result unknown for opcode %s", opcode.name());
	end

endmodule

// File: source/reg_file.sv
module reg_file (
	input logic clk,
	input logic rst_n,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	input logic [4:0] rd,
	input logic we,
	input rv_pkg::data_t wdata,

	output rv_pkg::data_t rdata1,
	output rv_pkg::data_t rdata2
);
	import rv_pkg::*;

	data_t regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= NULL;
			end
		end else if (we && rd != 5'd0) begin   // x0 never written
			regs[rd] <= wdata;
		end
	end

	assign rdata1 = (rs1 == 5'd0) ? NULL : regs[rs1];
	assign rdata2 = (rs2 == 5'd0) ? NULL : regs[rs2];

endmodule

// File: source/fetch_unit.sv
module fetch_unit #(
	parameter bit PREFETCH = 1'b1
) (
	input logic clk,
	input logic rst_n,
	input rv_pkg::data_t fetch_pc,
	input logic fetch_go,
	input logic grant_ack,
	input rv_pkg::data_t grant_rdata,

	output rv_pkg::instr_t instr,
	output logic instr_valid,
	output rv_pkg::mem_req_t req,
	output logic req_strobe
);
	import rv_pkg::*;

	logic  want;          // core waiting for a word
	data_t want_pc;
	logic  pending;       // own request out on the port
	data_t req_addr;
	logic  pf_valid;
	data_t pf_tag;
	data_t pf_word;

	logic  need, hit, deliver, issue, fill;
	data_t need_pc, issue_addr, deliver_word;

	always_comb begin
		need = fetch_go | want;
		need_pc = fetch_go ? fetch_pc : want_pc;
		hit = fetch_go && !pending && pf_valid && (pf_tag == fetch_pc);
		deliver = hit || (grant_ack && need && (req_addr == need_pc));
		deliver_word = hit ? pf_word : grant_rdata;
		fill = grant_ack && !need;   // prefetch came back, nobody asked yet
		if (deliver) begin
			issue = PREFETCH;
			issue_addr = need_pc + 32'd4;
		end else begin
			// stale word dropped, refetch the wanted one
			issue = (grant_ack && need) || (fetch_go && !pending);
			issue_addr = need_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			want <= 1'b0;
			pending <= 1'b0;
			pf_valid <= 1'b0;
			instr_valid <= 1'b0;
			req_strobe <= 1'b0;
		end else begin
			instr_valid <= deliver;
			req_strobe <= issue;
			if (issue)
				pending <= 1'b1;
			else if (grant_ack)
				pending <= 1'b0;
			if (deliver)
				want <= 1'b0;
			else if (fetch_go)
				want <= 1'b1;
			if (fill)
				pf_valid <= 1'b1;
			else if (fetch_go)
				pf_valid <= 1'b0;   // used on a hit, dropped on a miss
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_go)
			want_pc <= fetch_pc;
		if (deliver)
			instr <= instr_t'(deliver_word);
		if (issue)
			req_addr <= issue_addr;
		if (fill) begin
			pf_tag <= req_addr;
			pf_word <= grant_rdata;
		end
	end

	assign req = '{addr: req_addr, wdata: NULL, we: 1'b0};

	no_double_req: assert property (@(posedge clk) disable iff (!rst_n)
		req_strobe |-> !$past(pending) || $past(grant_ack));

endmodule

// File: source/lsu.sv
module lsu (
	input logic clk,
	input logic rst_n,
	input logic ls_go,
	input logic ls_we,
	input rv_pkg::data_t ls_addr,
	input rv_pkg::data_t ls_wdata,
	input logic grant_ack,
	input rv_pkg::data_t grant_rdata,

	output logic ls_done,
	output rv_pkg::data_t ls_rdata,
	output rv_pkg::mem_req_t req,
	output logic req_strobe
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_strobe <= 1'b0;
			ls_done <= 1'b0;
		end else begin
			req_strobe <= ls_go;    // one strobe per access
			ls_done <= grant_ack;
		end
	end

	// request held until the next access
	always_ff @(posedge clk) begin
		if (ls_go)
			req <= '{addr: ls_addr, wdata: ls_wdata, we: ls_we};
		if (grant_ack)
			ls_rdata <= grant_rdata;
	end

endmodule

// File: source/mem_arbiter.sv
module mem_arbiter (
	input logic clk,
	input logic rst_n,
	input rv_pkg::mem_req_t f_req,
	input logic f_strobe,
	input rv_pkg::mem_req_t l_req,
	input logic l_strobe,
	input logic mem_ack,
	input rv_pkg::data_t mem_rdata,

	output rv_pkg::mem_req_t mem_req,
	output logic mem_strobe,
	output logic f_ack,
	output logic l_ack,
	output rv_pkg::data_t rdata
);

	logic f_pend, l_pend;     // strobes not yet granted
	logic busy;
	logic owner_lsu;
	logic f_want, l_want, free, grant_f, grant_l;

	always_comb begin
		f_want = f_strobe | f_pend;
		l_want = l_strobe | l_pend;
		free = !busy | mem_ack;       // port frees on the ack cycle
		grant_l = free & l_want;      // lsu wins ties
		grant_f = free & f_want & !l_want;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			f_pend <= 1'b0;
			l_pend <= 1'b0;
			busy <= 1'b0;
			owner_lsu <= 1'b0;
			mem_strobe <= 1'b0;
		end else begin
			mem_strobe <= grant_f | grant_l;
			if (grant_f | grant_l) begin
				busy <= 1'b1;
				owner_lsu <= grant_l;
			end else if (mem_ack) begin
				busy <= 1'b0;
			end
			f_pend <= f_want & !grant_f;
			l_pend <= l_want & !grant_l;
		end
	end

	assign mem_req = owner_lsu ? l_req : f_req;
	assign f_ack = mem_ack & busy & !owner_lsu;
	assign l_ack = mem_ack & busy & owner_lsu;
	assign rdata = mem_rdata;

	// every ack reaches exactly one owner, never both
	one_owner: assert property (@(posedge clk) disable iff (!rst_n) mem_ack |-> (f_ack ^ l_ack));

endmodule

// File: source/core_ctrl.sv
module core_ctrl #(
	parameter rv_pkg::data_t RESET_PC = '0
) (
	input logic clk,
	input logic rst_n,
	input rv_pkg::instr_t instr,
	input logic instr_valid,
	input logic ls_done,
	input rv_pkg::data_t ls_rdata,
	input rv_pkg::data_t rdata1,
	input rv_pkg::data_t rdata2,

	output rv_pkg::data_t fetch_pc,
	output logic fetch_go,
	output logic ls_go,
	output logic ls_we,
	output rv_pkg::data_t ls_addr,
	output rv_pkg::data_t ls_wdata,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output logic rf_we,
	output rv_pkg::data_t rf_wdata,
	output logic retire_valid,
	output rv_pkg::retire_t retire
);
	import rv_pkg::*;

	core_state_t state;
	data_t  pc, next_pc;
	instr_t ir;              // instruction being executed
	data_t  result;
	logic   wb_we;
	logic   fetch_sent;
	data_t  c_out;
	logic   rd_wr;
	logic   taken, is_jump, is_mem, commit;
	data_t  link_pc, target;

	alu u_alu (
		.instr(ir),
		.a_in(rdata1),
		.b_in(rdata2),
		.pc(pc),
		.c_out(c_out),
		.rd_wr(rd_wr)
	);

	always_comb begin : branch_resolve
		case (ir.funct3)
			BEQ:     taken = rdata1 == rdata2;
			BNE:     taken = rdata1 != rdata2;
			BLT:     taken = $signed(rdata1) < $signed(rdata2);
			BGE:     taken = $signed(rdata1) >= $signed(rdata2);
			BLTU:    taken = rdata1 < rdata2;
			BGEU:    taken = rdata1 >= rdata2;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin : next_pc_sel
		is_jump = ir.opcode inside {JAL, JALR};
		is_mem = ir.opcode inside {LOAD, STORE};
		link_pc = pc + 32'd4;
		if (is_jump)
			target = c_out;                  // computed by the alu
		else if (ir.opcode == B && taken)
			target = pc + get_imm(ir);
		else
			target = link_pc;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= FETCH;
			pc <= RESET_PC;
			fetch_sent <= 1'b0;
			fetch_go <= 1'b0;
			ls_go <= 1'b0;
		end else begin
			fetch_go <= 1'b0;
			ls_go <= 1'b0;
			case (state)
				FETCH: begin
					if (!fetch_sent) begin
						fetch_go <= 1'b1;
						fetch_sent <= 1'b1;
					end
					if (instr_valid) begin
						fetch_sent <= 1'b0;
						state <= EXECUTE;
					end
				end
				EXECUTE: begin
					ls_go <= is_mem;
					state <= is_mem ? MEM_WAIT : WRITEBACK;
				end
				MEM_WAIT: begin
					if (ls_done)
						state <= WRITEBACK;
				end
				WRITEBACK: begin
					pc <= next_pc;
					state <= FETCH;
				end
				default: state <= FETCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FETCH && instr_valid)
			ir <= instr;
		if (state == EXECUTE) begin
			next_pc <= target;
			wb_we <= rd_wr;
			result <= is_jump ? link_pc : c_out;
			ls_we <= ir.opcode == STORE;
			ls_addr <= c_out;
			ls_wdata <= rdata2;
		end
		if (state == MEM_WAIT && ls_done && ir.opcode == LOAD)
			result <= ls_rdata;   // load data replaces the address
	end

	assign fetch_pc = pc;
	assign rs1 = ir.rs1;
	assign rs2 = ir.rs2;
	assign rd = ir.rd;
	assign rf_we = (state == WRITEBACK) && wb_we;
	assign rf_wdata = result;

	assign commit = wb_we && (ir.rd != 5'd0);
	assign retire_valid = state == WRITEBACK;
	assign retire = '{pc: pc, rd: ir.rd, we: commit, data: commit ? result : NULL};

endmodule

// File: source/cpu_top.sv
module cpu_top #(
	parameter rv_pkg::data_t RESET_PC = '0,
	parameter bit PREFETCH = 1'b1
) (
	input logic clk,
	input logic rst_n,
	input logic mem_ack,
	input rv_pkg::data_t mem_rdata,

	output rv_pkg::mem_req_t mem_req,
	output logic mem_strobe,
	output logic retire_valid,
	output rv_pkg::retire_t retire
);
	import rv_pkg::*;

	data_t    fetch_pc;
	logic     fetch_go;
	instr_t   instr;
	logic     instr_valid;
	logic     ls_go, ls_we, ls_done;
	data_t    ls_addr, ls_wdata, ls_rdata;
	logic [4:0] rs1, rs2, rd;
	logic     rf_we;
	data_t    rf_wdata, rdata1, rdata2;
	mem_req_t f_req, l_req;
	logic     f_strobe, l_strobe;
	logic     f_ack, l_ack;
	data_t    grant_rdata;   // shared, qualified by each ack

	core_ctrl #(.RESET_PC(RESET_PC)) u_core_ctrl (
		.clk(clk), .rst_n(rst_n),
		.instr(instr), .instr_valid(instr_valid),
		.ls_done(ls_done), .ls_rdata(ls_rdata),
		.rdata1(rdata1), .rdata2(rdata2),
		.fetch_pc(fetch_pc), .fetch_go(fetch_go),
		.ls_go(ls_go), .ls_we(ls_we), .ls_addr(ls_addr), .ls_wdata(ls_wdata),
		.rs1(rs1), .rs2(rs2), .rd(rd), .rf_we(rf_we), .rf_wdata(rf_wdata),
		.retire_valid(retire_valid), .retire(retire)
	);

	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n),
		.rs1(rs1), .rs2(rs2), .rd(rd), .we(rf_we), .wdata(rf_wdata),
		.rdata1(rdata1), .rdata2(rdata2)
	);

	fetch_unit #(.PREFETCH(PREFETCH)) u_fetch_unit (
		.clk(clk), .rst_n(rst_n),
		.fetch_pc(fetch_pc), .fetch_go(fetch_go),
		.grant_ack(f_ack), .grant_rdata(grant_rdata),
		.instr(instr), .instr_valid(instr_valid),
		.req(f_req), .req_strobe(f_strobe)
	);

	lsu u_lsu (
		.clk(clk), .rst_n(rst_n),
		.ls_go(ls_go), .ls_we(ls_we), .ls_addr(ls_addr), .ls_wdata(ls_wdata),
		.grant_ack(l_ack), .grant_rdata(grant_rdata),
		.ls_done(ls_done), .ls_rdata(ls_rdata),
		.req(l_req), .req_strobe(l_strobe)
	);

	mem_arbiter u_mem_arbiter (
		.clk(clk), .rst_n(rst_n),
		.f_req(f_req), .f_strobe(f_strobe),
		.l_req(l_req), .l_strobe(l_strobe),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.mem_req(mem_req), .mem_strobe(mem_strobe),
		.f_ack(f_ack), .l_ack(l_ack), .rdata(grant_rdata)
	);

endmodule

// File: test/retire_checker.sv
module retire_checker #(
	parameter int MEM_WORDS = 1024,
	parameter rv_pkg::data_t RESET_PC = '0
) (
	input logic clk,
	input logic rst_n,
	input logic retire_valid,
	input rv_pkg::retire_t retire,
	input rv_pkg::data_t image [MEM_WORDS],
	input rv_pkg::data_t seg_pc [6],
	input rv_pkg::data_t loop_pc,

	output logic done,
	output int fails
);
	timeunit 1ns;
	timeprecision 100ps;

	import rv_pkg::*;

	string names [6] = '{"alu_reg", "alu_imm", "shift_cmp", "branch_jump", "load_store",
		"x0_reg"};

	// instruction-set model state
	data_t x [32];
	data_t dmem [MEM_WORDS];
	data_t mpc;

	int cur_seg;
	int seg_pass;
	int seg_fail;
	logic seg_bad;
	retire_t first_exp, first_act;

	function automatic int seg_of(data_t pc);
		int s;
		s = 0;
		for (int i = 0; i < 6; i++) begin
			if (pc >= seg_pc[i])
				s = i;
		end
		return s;
	endfunction

	// one instruction of the model, returns what should retire
	function automatic retire_t model_step();
		data_t w, a, b, op2, addr, val, npc;
		data_t imm_i, imm_s, imm_b, imm_u, imm_j;
		logic [4:0] rd, sh;
		logic wr, is_r, tk;
		retire_t r;
		w = dmem[mpc[11:2]];
		rd = w[11:7];
		a = x[w[19:15]];
		b = x[w[24:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {w[31:12], 12'b0};
		imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		is_r = w[6:0] == 7'b0110011;
		op2 = is_r ? b : imm_i;
		sh = is_r ? b[4:0] : w[24:20];
		val = '0;
		wr = 1'b0;
		tk = 1'b0;
		npc = mpc + 32'd4;
		case (w[6:0])
			7'b0110011, 7'b0010011: begin
				wr = 1'b1;
				case (w[14:12])
					3'd0: val = (is_r && w[30]) ? a - b : a + op2;
					3'd1: val = a << sh;
					3'd2: val = {31'b0, $signed(a) < $signed(op2)};
					3'd3: val = {31'b0, a < op2};
					3'd4: val = a ^ op2;
					3'd5: val = w[30] ? data_t'($signed(a) >>> sh) : a >> sh;
					3'd6: val = a | op2;
					default: val = a & op2;
				endcase
			end
			7'b0110111: begin
				val = imm_u;
				wr = 1'b1;
			end
			7'b0010111: begin
				val = mpc + imm_u;
				wr = 1'b1;
			end
			7'b1101111: begin
				val = mpc + 32'd4;
				wr = 1'b1;
				npc = mpc + imm_j;
			end
			7'b1100111: begin
				val = mpc + 32'd4;
				wr = 1'b1;
				npc = (a + imm_i) & ~32'd1;
			end
			7'b1100011: begin
				case (w[14:12])
					3'd0: tk = a == b;
					3'd1: tk = a != b;
					3'd4: tk = $signed(a) < $signed(b);
					3'd5: tk = $signed(a) >= $signed(b);
					3'd6: tk = a < b;
					3'd7: tk = a >= b;
					default: tk = 1'b0;
				endcase
				if (tk)
					npc = mpc + imm_b;
			end
			7'b0000011: begin
				addr = a + imm_i;
				val = dmem[addr[11:2]];
				wr = 1'b1;
			end
			7'b0100011: begin
				addr = a + imm_s;
				dmem[addr[11:2]] = b;
			end
			default: wr = 1'b0;   // fence and system do nothing
		endcase
		r.pc = mpc;
		r.rd = rd;
		r.we = wr && (rd != 5'd0);
		r.data = r.we ? val : '0;
		if (r.we)
			x[rd] = val;
		mpc = npc;
		return r;
	endfunction

	task automatic report_seg();
		if (seg_bad) begin
			$display("FAILED %s expected pc=%h rd=%0d we=%b data=%h actual pc=%h rd=%0d we=%b data=%h",
				names[cur_seg], first_exp.pc, first_exp.rd, first_exp.we, first_exp.data,
				first_act.pc, first_act.rd, first_act.we, first_act.data);
			seg_fail++;
			fails++;
		end else begin
			$display("%s PASSED", names[cur_seg]);
			seg_pass++;
		end
		seg_bad = 1'b0;
	endtask

	task automatic close_run();
		$display("segments passed: %0d, failed: %0d", seg_pass, seg_fail);
		done = 1'b1;
	endtask

	task automatic check_one();
		retire_t exp;
		int s;
		if (retire.pc !== mpc) begin
			$display("%s: execution went down the wrong path, pc %h retired where %h was due",
				names[cur_seg], retire.pc, mpc);
			fails++;
			seg_fail++;
			close_run();
		end else begin
			s = seg_of(mpc);
			if (s != cur_seg) begin
				report_seg();
				cur_seg = s;
			end
			exp = model_step();
			if (retire !== exp && !seg_bad) begin
				seg_bad = 1'b1;
				first_exp = exp;
				first_act = retire;
			end
			if (exp.pc == loop_pc) begin   // end of program reached
				report_seg();
				close_run();
			end
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				x[i] = '0;
			for (int i = 0; i < MEM_WORDS; i++)
				dmem[i] = image[i];
			mpc = RESET_PC;
			cur_seg = 0;
			seg_pass = 0;
			seg_fail = 0;
			seg_bad = 1'b0;
			fails = 0;
			done = 1'b0;
		end else if (retire_valid && !done) begin
			check_one();
		end
	end

endmodule

// File: test/tb_top.sv
module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	import rv_pkg::*;

	localparam int MEM_WORDS = 1024;
	localparam data_t RESET_PC = 32'h0;

	logic clk;
	logic rst_n;
	logic mem_ack;
	data_t mem_rdata;
	mem_req_t mem_req;
	logic mem_strobe;
	logic retire_valid;
	retire_t retire;

	data_t mem [MEM_WORDS];
	data_t seg_pc [6];
	data_t loop_pc;
	data_t pc_a;          // assembly address
	int seed = 95528;
	int n_instr;
	int cycles;
	logic done;
	int fails;

	cpu_top #(.RESET_PC(RESET_PC), .PREFETCH(1'b1)) UUT (
		.clk(clk), .rst_n(rst_n),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.mem_req(mem_req), .mem_strobe(mem_strobe),
		.retire_valid(retire_valid), .retire(retire)
	);

	retire_checker #(.MEM_WORDS(MEM_WORDS), .RESET_PC(RESET_PC)) u_checker (
		.clk(clk), .rst_n(rst_n),
		.retire_valid(retire_valid), .retire(retire),
		.image(mem), .seg_pc(seg_pc), .loop_pc(loop_pc),
		.done(done), .fails(fails)
	);

	function automatic data_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic data_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic data_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic data_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic data_t enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic emit(data_t w);
		mem[pc_a[11:2]] = w;
		pc_a = pc_a + 32'd4;
	endtask

	task automatic li(logic [4:0] rd, data_t val);
		data_t up;
		up = (val + 32'h800) >> 12;   // rounds for the signed low part
		emit({up[19:0], rd, 7'b0110111});
		emit(enc_i(val[11:0], rd, 3'd0, rd, 7'b0010011));
	endtask

	task automatic rop(logic [2:0] f3, logic [6:0] f7, logic [4:0] rd, logic [4:0] rs1,
			logic [4:0] rs2);
		emit(enc_r(f7, rs2, rs1, f3, rd, 7'b0110011));
	endtask

	task automatic iop(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
		emit(enc_i(imm, rs1, f3, rd, 7'b0010011));
	endtask

	// branch over one marker increment
	task automatic br(logic [2:0] f3, logic [4:0] ra, logic [4:0] rb);
		emit(enc_b(13'd8, rb, ra, f3));
		iop(3'd0, 5'd20, 5'd20, 12'd1);
	endtask

	initial begin : build_program
		for (int k = 0; k < MEM_WORDS; k++)
			mem[k] = (k << 2) * 32'h9e3779b9 ^ 32'h5a5a0000;   // address hash fill
		pc_a = RESET_PC;
		seg_pc[0] = pc_a;
		li(5'd1, $random(seed));
		li(5'd2, $random(seed));
		rop(3'd0, 7'h00, 5'd3, 5'd1, 5'd2);
		rop(3'd0, 7'h20, 5'd4, 5'd1, 5'd2);   // sub
		rop(3'd7, 7'h00, 5'd5, 5'd1, 5'd2);
		rop(3'd6, 7'h00, 5'd6, 5'd1, 5'd2);
		rop(3'd4, 7'h00, 5'd7, 5'd1, 5'd2);
		rop(3'd0, 7'h00, 5'd0, 5'd1, 5'd2);
		rop(3'd0, 7'h00, 5'd8, 5'd0, 5'd1);
		seg_pc[1] = pc_a;
		li(5'd1, $random(seed));
		iop(3'd0, 5'd3, 5'd1, 12'h9c3);       // negative immediate
		iop(3'd7, 5'd4, 5'd1, 12'($random(seed)));
		iop(3'd6, 5'd5, 5'd1, 12'($random(seed)));
		iop(3'd4, 5'd6, 5'd1, 12'hfff);
		emit({20'($random(seed)), 5'd7, 7'b0110111});
		emit({20'($random(seed)), 5'd8, 7'b0010111});
		iop(3'd0, 5'd0, 5'd1, 12'd5);
		rop(3'd6, 7'h00, 5'd9, 5'd0, 5'd3);
		seg_pc[2] = pc_a;
		li(5'd1, 32'h8000_0000);
		li(5'd2, 32'h7fff_ffff);
		li(5'd3, 32'hffff_ffff);
		li(5'd4, $random(seed));
		rop(3'd1, 7'h00, 5'd5, 5'd4, 5'd2);
		rop(3'd5, 7'h00, 5'd6, 5'd1, 5'd4);
		rop(3'd5, 7'h20, 5'd7, 5'd1, 5'd4);   // sra
		iop(3'd1, 5'd8, 5'd4, 12'd7);
		iop(3'd5, 5'd9, 5'd1, 12'd3);
		iop(3'd5, 5'd10, 5'd1, 12'h403);     // srai
		rop(3'd2, 7'h00, 5'd11, 5'd1, 5'd2);
		rop(3'd3, 7'h00, 5'd12, 5'd1, 5'd2);
		rop(3'd2, 7'h00, 5'd13, 5'd2, 5'd1);
		rop(3'd3, 7'h00, 5'd14, 5'd3, 5'd4);
		iop(3'd2, 5'd15, 5'd1, 12'hfff);
		iop(3'd3, 5'd16, 5'd2, 12'hfff);
		iop(3'd2, 5'd17, 5'd3, 12'd0);
		iop(3'd3, 5'd0, 5'd0, 12'd1);
		rop(3'd0, 7'h00, 5'd18, 5'd0, 5'd0);
		seg_pc[3] = pc_a;
		li(5'd1, 32'h8000_0000);
		iop(3'd0, 5'd2, 5'd0, 12'd5);
		iop(3'd0, 5'd3, 5'd0, 12'd5);
		iop(3'd0, 5'd4, 5'd0, 12'd7);
		br(3'd0, 5'd2, 5'd3);   // taken then not taken, per branch
		br(3'd0, 5'd2, 5'd4);
		br(3'd1, 5'd2, 5'd4);
		br(3'd1, 5'd2, 5'd3);
		br(3'd4, 5'd1, 5'd2);
		br(3'd4, 5'd4, 5'd2);
		br(3'd5, 5'd2, 5'd1);
		br(3'd5, 5'd1, 5'd2);
		br(3'd6, 5'd2, 5'd1);
		br(3'd6, 5'd1, 5'd2);
		br(3'd7, 5'd1, 5'd2);
		br(3'd7, 5'd2, 5'd4);
		emit(enc_j(21'd8, 5'd5));
		iop(3'd0, 5'd20, 5'd20, 12'd1);      // skipped by jal
		emit({20'd0, 5'd6, 7'b0010111});
		emit(enc_i(12'd12, 5'd6, 3'd0, 5'd7, 7'b1100111));
		iop(3'd0, 5'd20, 5'd20, 12'd1);      // skipped by jalr
		iop(3'd0, 5'd0, 5'd4, 12'd9);        // lost on x0
		rop(3'd0, 7'h00, 5'd8, 5'd0, 5'd20);
		seg_pc[4] = pc_a;
		li(5'd10, 32'h800);
		li(5'd11, $random(seed));
		li(5'd12, $random(seed));
		emit(enc_s(12'd0, 5'd11, 5'd10));
		emit(enc_s(12'd4, 5'd12, 5'd10));
		emit(enc_i(12'd0, 5'd10, 3'd2, 5'd13, 7'b0000011));
		emit(enc_i(12'd4, 5'd10, 3'd2, 5'd14, 7'b0000011));
		emit(enc_s(12'd8, 5'd13, 5'd10));
		emit(enc_i(12'd8, 5'd10, 3'd2, 5'd15, 7'b0000011));
		emit(enc_s(12'd0, 5'd12, 5'd10));
		emit(enc_i(12'd0, 5'd10, 3'd2, 5'd16, 7'b0000011));
		emit(enc_i(12'd64, 5'd10, 3'd2, 5'd17, 7'b0000011));   // untouched fill word
		emit(enc_i(12'd0, 5'd10, 3'd2, 5'd0, 7'b0000011));
		rop(3'd0, 7'h00, 5'd18, 5'd0, 5'd11);
		seg_pc[5] = pc_a;
		emit({20'($random(seed)), 5'd0, 7'b0110111});
		emit({20'h12345, 5'd0, 7'b0010111});
		emit(enc_j(21'd4, 5'd0));
		rop(3'd0, 7'h00, 5'd1, 5'd0, 5'd0);
		emit(enc_s(12'd12, 5'd0, 5'd10));
		emit(enc_i(12'd12, 5'd10, 3'd2, 5'd2, 7'b0000011));
		loop_pc = pc_a;
		emit(enc_j(21'd0, 5'd0));             // spin here
		n_instr = (pc_a - RESET_PC) >> 2;
	end

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// memory with a random ack delay of 1 to 3 cycles
	initial begin : memory_model
		int d;
		mem_req_t rq;
		mem_ack = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clk);
			#1;
			while (mem_strobe) begin
				rq = mem_req;
				d = 1 + ($unsigned($random(seed)) % 3);
				repeat (d) @(posedge clk);
				#1;
				mem_ack = 1'b1;
				mem_rdata = mem[rq.addr[11:2]];
				if (rq.we)
					mem[rq.addr[11:2]] = rq.wdata;
				@(posedge clk);
				#1;
				mem_ack = 1'b0;
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		cycles = 0;
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		while (!done && cycles < n_instr * 12) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (done && fails == 0) begin
			$display("TEST OK");
		end else begin
			if (!done)
				$display("simulation timed out after %0d cycles", cycles);
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
source/rv_pkg.sv
source/alu.sv
source/reg_file.sv
source/fetch_unit.sv
source/lsu.sv
source/mem_arbiter.sv
source/core_ctrl.sv
source/cpu_top.sv
test/retire_checker.sv
test/tb_top.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_top -Mdir obj_dir -f list.f
	./obj_dir/Vtb_top > sim.log 2>&1; cat sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
